// ==== common/glbl_reg_pkg.sv ====
//------------------------------------------------
// Global register block shared definitions
// Bus widths, register map, reset words, field
// positions and interrupt source map
//------------------------------------------------
package glbl_reg_pkg;

   // Register bus geometry
   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 5;
   localparam int BE_W        = 4;
   localparam int NUM_REGS    = 32;
   localparam int NUM_SW_REGS = 8;

   //------------------------------------------------
   // Register word addresses
   //------------------------------------------------
   localparam logic [ADDR_W-1:0] ADDR_CHIP_ID    = 5'd0;
   localparam logic [ADDR_W-1:0] ADDR_RST_CTRL   = 5'd1;
   localparam logic [ADDR_W-1:0] ADDR_CFG1       = 5'd2;
   localparam logic [ADDR_W-1:0] ADDR_INTR_MASK  = 5'd3;
   localparam logic [ADDR_W-1:0] ADDR_INTR_STAT  = 5'd4;
   localparam logic [ADDR_W-1:0] ADDR_MULTI_FUNC = 5'd5;
   localparam logic [ADDR_W-1:0] ADDR_MAILBOX    = 5'd15;
   localparam logic [ADDR_W-1:0] ADDR_SW_BASE    = 5'd16;

   // Chip ID fields, "RD" in ASCII for the maker code
   localparam logic [15:0] CHIP_MANU_ID  = 16'h8268;
   localparam logic [3:0]  CHIP_CORE_CNT = 4'h4;
   localparam logic [3:0]  CHIP_NUM      = 4'h5;
   localparam logic [7:0]  CHIP_REV      = 8'h01;
   localparam logic [DATA_W-1:0] CHIP_ID_WORD =
      {CHIP_MANU_ID, CHIP_CORE_CNT, CHIP_NUM, CHIP_REV};

   //------------------------------------------------
   // Reset words
   //------------------------------------------------
   // CPU interface and QSPI out of reset, core 0 only on boot strap
   localparam logic [DATA_W-1:0] RST_CTRL_DEFAULT      = 32'h0000_0003;
   localparam logic [DATA_W-1:0] RST_CTRL_BOOT_DEFAULT = 32'h0000_0103;
   // UART master on at power-up
   localparam logic [DATA_W-1:0] MULTI_FUNC_DEFAULT    = 32'h8000_0000;
   // Index 0 sits in the low word
   localparam logic [NUM_SW_REGS-1:0][DATA_W-1:0] SW_REG_DEFAULTS = {
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
      32'h0005_2000,
      32'h1505_2024,
      32'h8273_8343
   };

   // Reset-control bit map, all active low
   localparam int RST_BIT_CPU_INTF = 0;
   localparam int RST_BIT_QSPIM    = 1;
   localparam int RST_BIT_SSPIM    = 2;
   localparam int RST_BIT_UART0    = 3;
   localparam int RST_BIT_I2CM     = 4;
   localparam int RST_BIT_USB      = 5;
   localparam int RST_BIT_UART1    = 6;
   localparam int RST_LSB_CPU_CORE = 8;

   // Configuration word fields
   localparam int CFG1_LSB_RISCV_CTRL = 16;
   localparam int CFG1_BIT_SOFT_IRQ   = 3;
   localparam int CFG1_LSB_USER_IRQ   = 0;
   localparam int CFG1_LSB_SRAM_EDGE  = 12;
   localparam int CFG1_LSB_CACHE_BYP  = 26;

   // Interrupt sources, bits 7:5 unused
   localparam int INTR_BIT_TIMER = 0;
   localparam int INTR_BIT_I2CM  = 3;
   localparam int INTR_BIT_USB   = 4;
   localparam int INTR_LSB_GPIO  = 8;

   // Byte-enabled update of one register word
   function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_word,
                                                 input logic [DATA_W-1:0] new_word,
                                                 input logic [BE_W-1:0]   be);
      logic [DATA_W-1:0] res;
      res = old_word;
      for (int b = 0; b < BE_W; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

// ==== glbl_reg/reg_bus_ctrl.sv ====
//------------------------------------------------
// Register bus controller
// One-cycle ack, one-shot write strobes and the
// registered read multiplexer
//------------------------------------------------
`timescale 1ns/1ps

module reg_bus_ctrl (
   input  logic                               mclk,
   input  logic                               s_reset_n,
   input  logic                               reg_cs,
   input  logic                               reg_wr,
   input  logic [glbl_reg_pkg::ADDR_W-1:0]    reg_addr,
   input  logic [glbl_reg_pkg::BE_W-1:0]      reg_be,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    reg_wdata,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    rst_ctrl_q,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    cfg1_q,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    multi_func_q,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    intr_mask_q,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    intr_stat_q,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    mailbox_q,
   input  logic [glbl_reg_pkg::DATA_W-1:0]    sw_reg_q [glbl_reg_pkg::NUM_SW_REGS],
   output logic [glbl_reg_pkg::DATA_W-1:0]    reg_rdata,
   output logic                               reg_ack,
   output logic [glbl_reg_pkg::NUM_REGS-1:0]  wr_stb,
   output logic [glbl_reg_pkg::BE_W-1:0]      wr_be,
   output logic [glbl_reg_pkg::DATA_W-1:0]    wr_data
);

   logic                              req_new;
   logic [glbl_reg_pkg::DATA_W-1:0]   rd_word;

   // Request cycle, cs seen while ack still low
   assign req_new = reg_cs & ~reg_ack;

   //------------------------------------------------
   // Write decode
   //------------------------------------------------
   // One-hot strobe, only in the request cycle so a held cs never rewrites
   assign wr_stb = (req_new & reg_wr) ?
                   ({{(glbl_reg_pkg::NUM_REGS-1){1'b0}}, 1'b1} << reg_addr) : '0;
   assign wr_be   = reg_be;
   assign wr_data = reg_wdata;

   //------------------------------------------------
   // Read mux
   //------------------------------------------------
   always_comb begin
      rd_word = '0;
      case (reg_addr)
         glbl_reg_pkg::ADDR_CHIP_ID:    rd_word = glbl_reg_pkg::CHIP_ID_WORD;
         glbl_reg_pkg::ADDR_RST_CTRL:   rd_word = rst_ctrl_q;
         glbl_reg_pkg::ADDR_CFG1:       rd_word = cfg1_q;
         glbl_reg_pkg::ADDR_INTR_MASK:  rd_word = intr_mask_q;
         glbl_reg_pkg::ADDR_INTR_STAT:  rd_word = intr_stat_q;
         glbl_reg_pkg::ADDR_MULTI_FUNC: rd_word = multi_func_q;
         glbl_reg_pkg::ADDR_MAILBOX:    rd_word = mailbox_q;
         default: begin
            // Software register window, anything else reads zero
            for (int i = 0; i < glbl_reg_pkg::NUM_SW_REGS; i++) begin
               if (int'(reg_addr) == int'(glbl_reg_pkg::ADDR_SW_BASE) + i) begin
                  rd_word = sw_reg_q[i];
               end
            end
         end
      endcase
   end

   // Ack and read data on the same edge, ack lasts one cycle
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack   <= 1'b0;
         reg_rdata <= '0;
      end else if (req_new) begin
         reg_ack   <= 1'b1;
         reg_rdata <= rd_word;
      end else begin
         reg_ack   <= 1'b0;
      end
   end

endmodule

// ==== glbl_reg/rst_cfg_regs.sv ====
//------------------------------------------------
// Reset control, core configuration and pin mux
// registers with strap-based reset words
//------------------------------------------------
`timescale 1ns/1ps

module rst_cfg_regs (
   input  logic                             mclk,
   input  logic                             s_reset_n,
   input  logic                             wr_stb_rst,
   input  logic                             wr_stb_cfg1,
   input  logic                             wr_stb_multi_func,
   input  logic [glbl_reg_pkg::BE_W-1:0]    wr_be,
   input  logic [glbl_reg_pkg::DATA_W-1:0]  wr_data,
   input  logic                             strap_riscv_bmode,
   input  logic [1:0]                       strap_cache_bypass,
   input  logic [3:0]                       strap_sram_clk_edge,
   output logic [glbl_reg_pkg::DATA_W-1:0]  rst_ctrl_q,
   output logic [glbl_reg_pkg::DATA_W-1:0]  cfg1_q,
   output logic [glbl_reg_pkg::DATA_W-1:0]  multi_func_q,
   output logic [3:0]                       cpu_core_rst_n,
   output logic                             cpu_intf_rst_n,
   output logic                             qspim_rst_n,
   output logic                             sspim_rst_n,
   output logic [1:0]                       uart_rst_n,
   output logic                             i2cm_rst_n,
   output logic                             usb_rst_n,
   output logic [15:0]                      cfg_riscv_ctrl,
   output logic                             soft_irq,
   output logic [2:0]                       user_irq,
   output logic [31:0]                      cfg_multi_func_sel
);

   logic [glbl_reg_pkg::DATA_W-1:0] rst_ctrl_init;
   logic [glbl_reg_pkg::DATA_W-1:0] cfg1_init;

   //------------------------------------------------
   // Strap-dependent reset words
   //------------------------------------------------
   // Boot strap decides whether core 0 leaves reset on its own
   assign rst_ctrl_init = strap_riscv_bmode ? glbl_reg_pkg::RST_CTRL_BOOT_DEFAULT
                                            : glbl_reg_pkg::RST_CTRL_DEFAULT;

   always_comb begin
      cfg1_init = '0;
      cfg1_init[glbl_reg_pkg::CFG1_LSB_SRAM_EDGE +: 4] = strap_sram_clk_edge;
      cfg1_init[glbl_reg_pkg::CFG1_LSB_CACHE_BYP +: 2] = strap_cache_bypass;
   end

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl_q   <= rst_ctrl_init;
         cfg1_q       <= cfg1_init;
         multi_func_q <= glbl_reg_pkg::MULTI_FUNC_DEFAULT;
      end else begin
         if (wr_stb_rst) begin
            rst_ctrl_q <= glbl_reg_pkg::be_merge(rst_ctrl_q, wr_data, wr_be);
         end
         if (wr_stb_cfg1) begin
            cfg1_q <= glbl_reg_pkg::be_merge(cfg1_q, wr_data, wr_be);
         end
         if (wr_stb_multi_func) begin
            multi_func_q <= glbl_reg_pkg::be_merge(multi_func_q, wr_data, wr_be);
         end
      end
   end

   //------------------------------------------------
   // Block resets, one bit each
   //------------------------------------------------
   assign cpu_intf_rst_n = rst_ctrl_q[glbl_reg_pkg::RST_BIT_CPU_INTF];
   assign qspim_rst_n    = rst_ctrl_q[glbl_reg_pkg::RST_BIT_QSPIM];
   assign sspim_rst_n    = rst_ctrl_q[glbl_reg_pkg::RST_BIT_SSPIM];
   assign uart_rst_n     = {rst_ctrl_q[glbl_reg_pkg::RST_BIT_UART1],
                            rst_ctrl_q[glbl_reg_pkg::RST_BIT_UART0]};
   assign i2cm_rst_n     = rst_ctrl_q[glbl_reg_pkg::RST_BIT_I2CM];
   assign usb_rst_n      = rst_ctrl_q[glbl_reg_pkg::RST_BIT_USB];
   assign cpu_core_rst_n = rst_ctrl_q[glbl_reg_pkg::RST_LSB_CPU_CORE +: 4];

   // Core config, bits 7:4 kept for readback only
   assign cfg_riscv_ctrl = cfg1_q[glbl_reg_pkg::CFG1_LSB_RISCV_CTRL +: 16];
   assign soft_irq       = cfg1_q[glbl_reg_pkg::CFG1_BIT_SOFT_IRQ];
   assign user_irq       = cfg1_q[glbl_reg_pkg::CFG1_LSB_USER_IRQ +: 3];

   assign cfg_multi_func_sel = multi_func_q;

endmodule

// ==== glbl_reg/intr_ctrl.sv ====
//------------------------------------------------
// Interrupt controller
// Byte-writable mask, sticky W1C status and the
// masked interrupt lines
//------------------------------------------------
`timescale 1ns/1ps

module intr_ctrl (
   input  logic                             mclk,
   input  logic                             s_reset_n,
   input  logic                             wr_stb_mask,
   input  logic                             wr_stb_stat,
   input  logic [glbl_reg_pkg::BE_W-1:0]    wr_be,
   input  logic [glbl_reg_pkg::DATA_W-1:0]  wr_data,
   input  logic [2:0]                       timer_intr,
   input  logic                             i2cm_intr,
   input  logic                             usb_intr,
   input  logic [31:0]                      gpio_intr,
   output logic [glbl_reg_pkg::DATA_W-1:0]  intr_mask_q,
   output logic [glbl_reg_pkg::DATA_W-1:0]  intr_stat_q,
   output logic [glbl_reg_pkg::DATA_W-1:0]  irq_lines
);

   logic [glbl_reg_pkg::DATA_W-1:0] hw_req;
   logic [glbl_reg_pkg::DATA_W-1:0] clr_bits;

   //------------------------------------------------
   // Source map
   //------------------------------------------------
   always_comb begin
      hw_req = '0;
      hw_req[glbl_reg_pkg::INTR_BIT_TIMER +: 3] = timer_intr;
      hw_req[glbl_reg_pkg::INTR_BIT_I2CM]       = i2cm_intr;
      hw_req[glbl_reg_pkg::INTR_BIT_USB]        = usb_intr;
      // GPIO 7:0 is port A, not a user interrupt source
      hw_req[glbl_reg_pkg::DATA_W-1:glbl_reg_pkg::INTR_LSB_GPIO] =
         gpio_intr[glbl_reg_pkg::DATA_W-1:glbl_reg_pkg::INTR_LSB_GPIO];
   end

   // Ones written in enabled bytes
   always_comb begin
      clr_bits = '0;
      if (wr_stb_stat) begin
         clr_bits = glbl_reg_pkg::be_merge('0, wr_data, wr_be);
      end
   end

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_mask_q <= '0;
         intr_stat_q <= '0;
      end else begin
         if (wr_stb_mask) begin
            intr_mask_q <= glbl_reg_pkg::be_merge(intr_mask_q, wr_data, wr_be);
         end
         // A live source beats a clear in the same cycle
         intr_stat_q <= (intr_stat_q & ~clr_bits) | hw_req;
      end
   end

   assign irq_lines = intr_mask_q & intr_stat_q;

endmodule

// ==== glbl_reg/sw_scratch_regs.sv ====
//------------------------------------------------
// Mailbox and software scratch registers
//------------------------------------------------
`timescale 1ns/1ps

module sw_scratch_regs (
   input  logic                                  mclk,
   input  logic                                  s_reset_n,
   input  logic                                  wr_stb_mailbox,
   input  logic [glbl_reg_pkg::NUM_SW_REGS-1:0]  wr_stb_sw,
   input  logic [glbl_reg_pkg::BE_W-1:0]         wr_be,
   input  logic [glbl_reg_pkg::DATA_W-1:0]       wr_data,
   output logic [glbl_reg_pkg::DATA_W-1:0]       mailbox_q,
   output logic [glbl_reg_pkg::DATA_W-1:0]       sw_reg_q [glbl_reg_pkg::NUM_SW_REGS]
);

   // Mailbox between cores, cleared on reset
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         mailbox_q <= '0;
      end else if (wr_stb_mailbox) begin
         mailbox_q <= glbl_reg_pkg::be_merge(mailbox_q, wr_data, wr_be);
      end
   end

   //------------------------------------------------
   // Software registers
   //------------------------------------------------
   // Words 0 to 2 come up with signature, release date and revision
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         for (int i = 0; i < glbl_reg_pkg::NUM_SW_REGS; i++) begin
            sw_reg_q[i] <= glbl_reg_pkg::SW_REG_DEFAULTS[i];
         end
      end else begin
         for (int i = 0; i < glbl_reg_pkg::NUM_SW_REGS; i++) begin
            if (wr_stb_sw[i]) begin
               sw_reg_q[i] <= glbl_reg_pkg::be_merge(sw_reg_q[i], wr_data, wr_be);
            end
         end
      end
   end

endmodule

// ==== glbl_reg/glbl_reg.sv ====
//------------------------------------------------
// Global register block top
// Bus controller plus reset/config, interrupt and
// scratch register groups
//------------------------------------------------
`timescale 1ns/1ps

module glbl_reg (
   input  logic                             mclk,
   input  logic                             s_reset_n,
   input  logic                             reg_cs,
   input  logic                             reg_wr,
   input  logic [glbl_reg_pkg::ADDR_W-1:0]  reg_addr,
   input  logic [glbl_reg_pkg::BE_W-1:0]    reg_be,
   input  logic [glbl_reg_pkg::DATA_W-1:0]  reg_wdata,
   input  logic                             strap_riscv_bmode,
   input  logic [1:0]                       strap_cache_bypass,
   input  logic [3:0]                       strap_sram_clk_edge,
   input  logic [2:0]                       timer_intr,
   input  logic                             i2cm_intr,
   input  logic                             usb_intr,
   input  logic [31:0]                      gpio_intr,
   output logic [glbl_reg_pkg::DATA_W-1:0]  reg_rdata,
   output logic                             reg_ack,
   output logic [3:0]                       cpu_core_rst_n,
   output logic                             cpu_intf_rst_n,
   output logic                             qspim_rst_n,
   output logic                             sspim_rst_n,
   output logic [1:0]                       uart_rst_n,
   output logic                             i2cm_rst_n,
   output logic                             usb_rst_n,
   output logic [15:0]                      cfg_riscv_ctrl,
   output logic                             soft_irq,
   output logic [2:0]                       user_irq,
   output logic [31:0]                      cfg_multi_func_sel,
   output logic [31:0]                      irq_lines
);

   logic [glbl_reg_pkg::NUM_REGS-1:0] wr_stb;
   logic [glbl_reg_pkg::BE_W-1:0]     wr_be;
   logic [glbl_reg_pkg::DATA_W-1:0]   wr_data;
   // Stored words back to the read mux
   logic [glbl_reg_pkg::DATA_W-1:0]   rst_ctrl_q;
   logic [glbl_reg_pkg::DATA_W-1:0]   cfg1_q;
   logic [glbl_reg_pkg::DATA_W-1:0]   multi_func_q;
   logic [glbl_reg_pkg::DATA_W-1:0]   intr_mask_q;
   logic [glbl_reg_pkg::DATA_W-1:0]   intr_stat_q;
   logic [glbl_reg_pkg::DATA_W-1:0]   mailbox_q;
   logic [glbl_reg_pkg::DATA_W-1:0]   sw_reg_q [glbl_reg_pkg::NUM_SW_REGS];

   reg_bus_ctrl u_bus (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_cs       (reg_cs),
      .reg_wr       (reg_wr),
      .reg_addr     (reg_addr),
      .reg_be       (reg_be),
      .reg_wdata    (reg_wdata),
      .rst_ctrl_q   (rst_ctrl_q),
      .cfg1_q       (cfg1_q),
      .multi_func_q (multi_func_q),
      .intr_mask_q  (intr_mask_q),
      .intr_stat_q  (intr_stat_q),
      .mailbox_q    (mailbox_q),
      .sw_reg_q     (sw_reg_q),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack),
      .wr_stb       (wr_stb),
      .wr_be        (wr_be),
      .wr_data      (wr_data)
   );

   rst_cfg_regs u_rst_cfg (
      .mclk                (mclk),
      .s_reset_n           (s_reset_n),
      .wr_stb_rst          (wr_stb[glbl_reg_pkg::ADDR_RST_CTRL]),
      .wr_stb_cfg1         (wr_stb[glbl_reg_pkg::ADDR_CFG1]),
      .wr_stb_multi_func   (wr_stb[glbl_reg_pkg::ADDR_MULTI_FUNC]),
      .wr_be               (wr_be),
      .wr_data             (wr_data),
      .strap_riscv_bmode   (strap_riscv_bmode),
      .strap_cache_bypass  (strap_cache_bypass),
      .strap_sram_clk_edge (strap_sram_clk_edge),
      .rst_ctrl_q          (rst_ctrl_q),
      .cfg1_q              (cfg1_q),
      .multi_func_q        (multi_func_q),
      .cpu_core_rst_n      (cpu_core_rst_n),
      .cpu_intf_rst_n      (cpu_intf_rst_n),
      .qspim_rst_n         (qspim_rst_n),
      .sspim_rst_n         (sspim_rst_n),
      .uart_rst_n          (uart_rst_n),
      .i2cm_rst_n          (i2cm_rst_n),
      .usb_rst_n           (usb_rst_n),
      .cfg_riscv_ctrl      (cfg_riscv_ctrl),
      .soft_irq            (soft_irq),
      .user_irq            (user_irq),
      .cfg_multi_func_sel  (cfg_multi_func_sel)
   );

   intr_ctrl u_intr (
      .mclk        (mclk),
      .s_reset_n   (s_reset_n),
      .wr_stb_mask (wr_stb[glbl_reg_pkg::ADDR_INTR_MASK]),
      .wr_stb_stat (wr_stb[glbl_reg_pkg::ADDR_INTR_STAT]),
      .wr_be       (wr_be),
      .wr_data     (wr_data),
      .timer_intr  (timer_intr),
      .i2cm_intr   (i2cm_intr),
      .usb_intr    (usb_intr),
      .gpio_intr   (gpio_intr),
      .intr_mask_q (intr_mask_q),
      .intr_stat_q (intr_stat_q),
      .irq_lines   (irq_lines)
   );

   sw_scratch_regs u_scratch (
      .mclk           (mclk),
      .s_reset_n      (s_reset_n),
      .wr_stb_mailbox (wr_stb[glbl_reg_pkg::ADDR_MAILBOX]),
      .wr_stb_sw      (wr_stb[glbl_reg_pkg::ADDR_SW_BASE +: glbl_reg_pkg::NUM_SW_REGS]),
      .wr_be          (wr_be),
      .wr_data        (wr_data),
      .mailbox_q      (mailbox_q),
      .sw_reg_q       (sw_reg_q)
   );

endmodule

// ==== verif/glbl_reg_checker.sv ====
//------------------------------------------------
// Global register block checker
// Watches the bus handshake and compares read
// data, interrupt lines and control outputs
//------------------------------------------------
`timescale 1ns/1ps

module glbl_reg_checker (
   input  logic        mclk,
   input  logic        s_reset_n,
   input  logic        reg_cs,
   input  logic [4:0]  reg_addr,
   input  logic        reg_ack,
   input  logic [31:0] reg_rdata,
   input  logic [31:0] irq_lines,
   input  logic [3:0]  cpu_core_rst_n,
   input  logic        cpu_intf_rst_n,
   input  logic        qspim_rst_n,
   input  logic        sspim_rst_n,
   input  logic [1:0]  uart_rst_n,
   input  logic        i2cm_rst_n,
   input  logic        usb_rst_n,
   input  logic [15:0] cfg_riscv_ctrl,
   input  logic        soft_irq,
   input  logic [2:0]  user_irq,
   input  logic [31:0] cfg_multi_func_sel,
   input  logic [7:0]  chk_kind,
   input  logic [31:0] chk_exp,
   input  logic        chk_now,
   output logic [31:0] val_errs,
   output logic [31:0] proto_errs
);

   int          val_cnt   = 0;
   int          proto_cnt = 0;
   logic        req_seen  = 1'b0;
   logic [31:0] out_word;

   assign val_errs   = val_cnt;
   assign proto_errs = proto_cnt;

   // Control outputs packed like the reset word, config on top
   // 31:16 core ctrl, 15 soft irq, 14:12 user irq, 11:8 cores
   assign out_word = {cfg_riscv_ctrl, soft_irq, user_irq, cpu_core_rst_n, 1'b0,
                      uart_rst_n[1], usb_rst_n, i2cm_rst_n, uart_rst_n[0],
                      sspim_rst_n, qspim_rst_n, cpu_intf_rst_n};

   //------------------------------------------------
   // Handshake
   //------------------------------------------------
   // Sampled mid-cycle, away from the rising edge
   always @(negedge mclk) begin
      if (!s_reset_n) begin
         req_seen = 1'b0;
      end else begin
         if (req_seen && !reg_ack) begin
            $display("Bus error at %0t: ack missing one cycle after reg_cs", $time);
            proto_cnt++;
         end
         // Second ack cycle also lands here
         if (reg_ack && !req_seen) begin
            $display("Bus error at %0t: reg_ack high without a new request", $time);
            proto_cnt++;
         end
         req_seen = reg_cs & ~reg_ack;
      end
   end

   //------------------------------------------------
   // Value compares
   //------------------------------------------------
   always @(negedge mclk) begin
      if (s_reset_n) begin
         // Read data only at ack
         if (reg_ack && chk_kind == "R" && reg_rdata !== chk_exp) begin
            $display("FAIL reg_rdata expected 0x%08h actual 0x%08h at %0t",
                     chk_exp, reg_rdata, $time);
            val_cnt++;
         end
         // Pin select output follows its register word
         if (reg_ack && chk_kind == "R" && reg_addr == glbl_reg_pkg::ADDR_MULTI_FUNC &&
             cfg_multi_func_sel !== chk_exp) begin
            $display("FAIL cfg_multi_func_sel expected 0x%08h actual 0x%08h at %0t",
                     chk_exp, cfg_multi_func_sel, $time);
            val_cnt++;
         end
         if (chk_now && chk_kind == "I" && irq_lines !== chk_exp) begin
            $display("FAIL irq_lines expected 0x%08h actual 0x%08h at %0t",
                     chk_exp, irq_lines, $time);
            val_cnt++;
         end
         if (chk_now && chk_kind == "O" && out_word !== chk_exp) begin
            $display("FAIL control_outputs expected 0x%08h actual 0x%08h at %0t",
                     chk_exp, out_word, $time);
            val_cnt++;
         end
      end
   end

endmodule

// ==== verif/tb_glbl_reg.sv ====
//------------------------------------------------
// Global register block testbench
// Replays the case file on the register bus and
// drives the interrupt sources
//------------------------------------------------
`timescale 1ns/1ps

module tb_glbl_reg;

   localparam int CLK_PERIOD = 4;
   localparam int MAX_CASES  = 64;
   localparam int ACK_WAIT   = 4;

   logic        mclk;
   logic        s_reset_n;
   logic        reg_cs;
   logic        reg_wr;
   logic [4:0]  reg_addr;
   logic [3:0]  reg_be;
   logic [31:0] reg_wdata;
   logic        strap_riscv_bmode;
   logic [1:0]  strap_cache_bypass;
   logic [3:0]  strap_sram_clk_edge;
   logic [2:0]  timer_intr;
   logic        i2cm_intr;
   logic        usb_intr;
   logic [31:0] gpio_intr;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   logic [3:0]  cpu_core_rst_n;
   logic        cpu_intf_rst_n;
   logic        qspim_rst_n;
   logic        sspim_rst_n;
   logic [1:0]  uart_rst_n;
   logic        i2cm_rst_n;
   logic        usb_rst_n;
   logic [15:0] cfg_riscv_ctrl;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic [31:0] cfg_multi_func_sel;
   logic [31:0] irq_lines;

   // Checker side band
   logic [7:0]  chk_kind;
   logic [31:0] chk_exp;
   logic        chk_now;
   logic [31:0] val_errs;
   logic [31:0] proto_errs;

   //------------------------------------------------
   // Case table
   //------------------------------------------------
   logic [7:0]  case_kind [MAX_CASES];
   logic [4:0]  case_addr [MAX_CASES];
   logic [3:0]  case_be   [MAX_CASES];
   logic [31:0] case_wdata[MAX_CASES];
   logic [31:0] case_hw   [MAX_CASES];
   logic [31:0] case_exp  [MAX_CASES];
   int          n_cases;
   logic        load_done;
   logic        load_ok;

   glbl_reg glbl_reg_inst (.*);

   glbl_reg_checker checker_inst (.*);

   always #(CLK_PERIOD / 2) mclk = ~mclk;

   // Read the case file, one operation per line, # starts a comment
   task automatic load_cases(output logic ok);
      int                 fd;
      int                 code;
      logic [7:0]         kc;
      logic [31:0]        f_addr;
      logic [31:0]        f_be;
      logic [31:0]        f_wdata;
      logic [31:0]        f_hw;
      logic [31:0]        f_exp;
      logic [8*160-1:0]   skip_line;
      ok = 1'b1;
      fd = $fopen("verif/glbl_reg_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the case file verif/glbl_reg_cases.txt");
         ok = 1'b0;
      end else begin
         code = $fscanf(fd, " %c", kc);
         while (code == 1 && ok) begin
            if (kc == "#") begin
               code = $fgets(skip_line, fd);
            end else begin
               code = $fscanf(fd, "%h %h %h %h %h", f_addr, f_be, f_wdata, f_hw, f_exp);
               if (code != 5 || n_cases >= MAX_CASES ||
                   !(kc == "W" || kc == "R" || kc == "I" || kc == "O")) begin
                  $display("Case file entry %0d is malformed", n_cases);
                  ok = 1'b0;
               end else begin
                  case_kind[n_cases]  = kc;
                  case_addr[n_cases]  = f_addr[4:0];
                  case_be[n_cases]    = f_be[3:0];
                  case_wdata[n_cases] = f_wdata;
                  case_hw[n_cases]    = f_hw;
                  case_exp[n_cases]   = f_exp;
                  n_cases++;
               end
            end
            code = $fscanf(fd, " %c", kc);
         end
         $fclose(fd);
         if (ok && n_cases == 0) begin
            $display("The case file holds no cases");
            ok = 1'b0;
         end
      end
   endtask

   // Spread the interrupt word over the source pins
   // GPIO also sees the low byte, which has no source there
   task automatic drive_sources(input logic [31:0] hw);
      timer_intr <= hw[glbl_reg_pkg::INTR_BIT_TIMER +: 3];
      i2cm_intr  <= hw[glbl_reg_pkg::INTR_BIT_I2CM];
      usb_intr   <= hw[glbl_reg_pkg::INTR_BIT_USB];
      gpio_intr  <= hw;
   endtask

   // One bus request, held until ack, then cs low for a cycle
   task automatic bus_op(input int idx);
      int wait_cnt;
      @(posedge mclk);
      reg_cs    <= 1'b1;
      reg_wr    <= (case_kind[idx] == "W");
      reg_addr  <= case_addr[idx];
      reg_be    <= case_be[idx];
      reg_wdata <= case_wdata[idx];
      chk_kind  <= case_kind[idx];
      chk_exp   <= case_exp[idx];
      drive_sources(case_hw[idx]);
      wait_cnt = 0;
      do begin
         @(negedge mclk);
         wait_cnt++;
      end while (!reg_ack && wait_cnt < ACK_WAIT);
      @(posedge mclk);
      reg_cs <= 1'b0;
      reg_wr <= 1'b0;
   endtask

   // Output level check, sources settle for two edges first
   task automatic level_check(input int idx);
      @(posedge mclk);
      chk_kind <= case_kind[idx];
      chk_exp  <= case_exp[idx];
      drive_sources(case_hw[idx]);
      repeat (2) @(posedge mclk);
      chk_now <= 1'b1;
      @(posedge mclk);
      chk_now <= 1'b0;
   endtask

   initial begin
      mclk                = 1'b0;
      s_reset_n           = 1'b0;
      reg_cs              = 1'b0;
      reg_wr              = 1'b0;
      reg_addr            = '0;
      reg_be              = '0;
      reg_wdata           = '0;
      // Boot from core 0, cache bypassed, SRAM on rising edge
      strap_riscv_bmode   = 1'b1;
      strap_cache_bypass  = 2'b11;
      strap_sram_clk_edge = 4'b0000;
      timer_intr          = '0;
      i2cm_intr           = 1'b0;
      usb_intr            = 1'b0;
      gpio_intr           = '0;
      chk_kind            = 8'h00;
      chk_exp             = '0;
      chk_now             = 1'b0;
      n_cases             = 0;
      load_done           = 1'b0;
      load_cases(load_ok);
      if (!load_ok) begin
         $display("Test failed");
         $finish;
      end else begin
         load_done = 1'b1;
         repeat (2) @(posedge mclk);
         s_reset_n <= 1'b1;
         for (int i = 0; i < n_cases; i++) begin
            if (case_kind[i] == "W" || case_kind[i] == "R") begin
               bus_op(i);
            end else begin
               level_check(i);
            end
         end
         repeat (2) @(posedge mclk);
         $display("Run done: %0d cases, %0d value errors, %0d bus errors",
                  n_cases, val_errs, proto_errs);
         if (val_errs == 0 && proto_errs == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

   //------------------------------------------------
   // Watchdog
   //------------------------------------------------
   // Six cycles per case plus reset slack
   initial begin
      wait (load_done);
      #(n_cases * 6 * CLK_PERIOD + 100);
      $display("Watchdog expired before all cases were run");
      $display("Test failed");
      $finish;
   end

endmodule

// ==== verif/glbl_reg_cases.txt ====
# kind addr be wdata hw_intr expected (hex), W=write R=read I=irq_lines O=control outputs
# hw_intr is driven on the sources for the whole case, expected is ignored for W
R 00 f 00000000 00000000 82684501
R 01 f 00000000 00000000 00000103
R 02 f 00000000 00000000 0c000000
R 05 f 00000000 00000000 80000000
R 10 f 00000000 00000000 82738343
R 11 f 00000000 00000000 15052024
R 12 f 00000000 00000000 00052000
R 13 f 00000000 00000000 00000000
R 17 f 00000000 00000000 00000000
R 07 f 00000000 00000000 00000000
R 1f f 00000000 00000000 00000000
O 00 0 00000000 00000000 0c000103
I 00 0 00000000 00000000 00000000
W 0f 5 aabbccdd 00000000 00000000
R 0f f 00000000 00000000 00bb00dd
W 10 2 11223344 00000000 00000000
R 10 f 00000000 00000000 82733343
W 17 c deadbeef 00000000 00000000
R 17 f 00000000 00000000 dead0000
W 00 f ffffffff 00000000 00000000
R 00 f 00000000 00000000 82684501
W 05 3 0000abcd 00000000 00000000
R 05 f 00000000 00000000 8000abcd
W 01 f 00000a55 00000000 00000000
O 00 0 00000000 00000000 0c000a55
R 01 f 00000000 00000000 00000a55
W 02 f 123400fd 00000000 00000000
R 02 f 00000000 00000000 123400fd
O 00 0 00000000 00000000 1234da55
R 04 f 00000000 00000000 00000000
I 00 0 00000000 00000010 00000000
R 04 f 00000000 00000000 00000010
W 03 f 00000010 00000000 00000000
I 00 0 00000000 00000000 00000010
W 04 1 00000000 00000000 00000000
R 04 f 00000000 00000000 00000010
W 04 e 00000010 00000000 00000000
R 04 f 00000000 00000000 00000010
W 04 1 00000010 00000000 00000000
R 04 f 00000000 00000000 00000000
I 00 0 00000000 00000000 00000000
I 00 0 00000000 00000100 00000000
W 04 f 00000100 00000100 00000000
R 04 f 00000000 00000100 00000100
W 03 f 00000100 00000000 00000000
R 03 f 00000000 00000000 00000100
I 00 0 00000000 00000000 00000100
W 04 2 00000100 00000000 00000000
R 04 f 00000000 00000000 00000000
I 00 0 00000000 000000e7 00000000
R 04 f 00000000 00000000 00000007

// ==== flist.f ====
common/glbl_reg_pkg.sv
glbl_reg/reg_bus_ctrl.sv
glbl_reg/rst_cfg_regs.sv
glbl_reg/intr_ctrl.sv
glbl_reg/sw_scratch_regs.sv
glbl_reg/glbl_reg.sv
verif/glbl_reg_checker.sv
verif/tb_glbl_reg.sv
